// File: hw/procPkg.sv
// Shared types for the 16-bit word-addressed core; memories are 256 words and opcodes outside opcodeT are illegal
package procPkg;

   localparam int imemDepth = 256;                // Instruction words
   localparam int dmemDepth = 256;                // Data words
   localparam int addrBits  = 8;                  // Index width of both memories

   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opSubi = 5'b01001,
      opAndi = 5'b01010,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011                           // R-type, function in bits 1:0
   } opcodeT;

   typedef enum logic [1:0] {aluAdd, aluSub, aluXor, aluAnd} aluOpT;  // Same order as function bits

   typedef enum logic [1:0] {
      destLow,                                    // Bits 4:2, R-type rd
      destMid,                                    // Bits 7:5, I-type rd
      destHigh                                    // Bits 10:8, LBI
   } regDestT;

   typedef enum logic [1:0] {brNone, brIfZero, brIfNotZero, brJump} branchT;

   typedef struct packed {
      logic    regWrite;
      regDestT regDest;
      logic    aluSrcImm;                         // Second operand is imm instead of rt
      aluOpT   aluOp;
      logic    memRead;
      logic    memWrite;
      logic    memToReg;
      logic    immWide;                           // 8-bit immediate instead of 5-bit
      branchT  branch;
      logic    halt;
   } ctrlT;

   typedef struct packed {
      logic                valid;                 // One word per cycle while high
      logic [addrBits-1:0] addr;
      logic [15:0]         data;
   } imemLoadT;

   typedef struct packed {
      logic        valid;
      logic [2:0]  regNum;
      logic [15:0] data;
   } retireT;

endpackage

// File: hw/control.sv
// Purely combinational decode; any opcode not in opcodeT leaves ctrl all zero and raises illegal
`timescale 1ns/1ps

module control (
   input  logic [15:0]    instr,
   output procPkg::ctrlT  ctrl,
   output logic           illegal
);

   procPkg::opcodeT op;

   assign op = procPkg::opcodeT'(instr[15:11]);          // Out-of-range codes fall to default

   always_comb begin
      ctrl    = '0;                                      // No writes, no branch
      illegal = 1'b0;
      case (op)
         procPkg::opHalt: ctrl.halt = 1'b1;
         procPkg::opNop: ;                               // Nothing to do
         procPkg::opJ: ctrl.branch = procPkg::brJump;
         procPkg::opAddi, procPkg::opSubi, procPkg::opAndi: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDest   = procPkg::destMid;           // rd in 7:5
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = (op == procPkg::opAddi) ? procPkg::aluAdd :
                             (op == procPkg::opSubi) ? procPkg::aluSub : procPkg::aluAnd;
         end
         procPkg::opBeqz: begin
            ctrl.immWide = 1'b1;                         // 8-bit offset
            ctrl.branch  = procPkg::brIfZero;
         end
         procPkg::opBnez: begin
            ctrl.immWide = 1'b1;
            ctrl.branch  = procPkg::brIfNotZero;
         end
         procPkg::opSt: begin
            ctrl.aluSrcImm = 1'b1;                       // Address is rs + imm5
            ctrl.aluOp     = procPkg::aluAdd;
            ctrl.memWrite  = 1'b1;
         end
         procPkg::opLd: begin
            ctrl.regWrite  = 1'b1;
            ctrl.regDest   = procPkg::destMid;
            ctrl.aluSrcImm = 1'b1;
            ctrl.aluOp     = procPkg::aluAdd;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
         end
         procPkg::opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDest  = procPkg::destHigh;           // Target register in 10:8
            ctrl.immWide  = 1'b1;                        // Execute passes imm through
         end
         procPkg::opAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDest  = procPkg::destLow;            // rd in 4:2
            ctrl.aluOp    = procPkg::aluOpT'(instr[1:0]);
         end
         default: illegal = 1'b1;
      endcase
   end

endmodule

// File: hw/fetch.sv
// Loads and starts are ignored while running; PC indexes imem by its low 8 bits; idle issues NOP
`timescale 1ns/1ps

module fetch (
   input  logic              clk,
   input  logic              arstN,
   input  procPkg::imemLoadT imemLoad,
   input  logic              start,
   input  procPkg::ctrlT     ctrl,
   input  logic              illegal,
   input  logic              taken,
   input  logic [15:0]       target,
   output logic [15:0]       instr,
   output logic [15:0]       pc,
   output logic              halted,
   output logic              err
);

   typedef enum logic {stIdle, stRun} runStateT;

   runStateT    state;
   logic        running;
   logic [15:0] word;
   logic [15:0] imem [procPkg::imemDepth];

   assign running = (state == stRun);

   always_ff @(posedge clk) begin
      if (!running && imemLoad.valid) imem[imemLoad.addr] <= imemLoad.data;  // Load port
   end

   assign word  = imem[pc[procPkg::addrBits-1:0]];
   assign instr = running ? word : {procPkg::opNop, 11'd0};    // Idle core sees NOP

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state  <= stIdle;
         pc     <= 16'd0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!running) begin
         if (start) begin
            state  <= stRun;
            pc     <= 16'd0;                                    // Always run from 0
            halted <= 1'b0;                                     // err stays until reset
         end
      end else if (illegal) begin
         state  <= stIdle;                                      // Stop like HALT
         halted <= 1'b1;
         err    <= 1'b1;
      end else if (ctrl.halt) begin
         state  <= stIdle;
         halted <= 1'b1;
      end else begin
         pc <= taken ? target : pc + 16'd1;
      end
   end

   // A branch or jump past word 255 would wrap into the low words of imem
   assert property (@(posedge clk) disable iff (!arstN)
      running |-> (pc[15:procPkg::addrBits] == '0))
      else $error("fetch: pc 0x%04h beyond instruction memory", pc);

endmodule

// File: hw/decode.sv
// Eight registers clear only on reset and persist across halts; reads are asynchronous
`timescale 1ns/1ps

module decode (
   input  logic          clk,
   input  logic          arstN,
   input  logic [15:0]   instr,
   input  procPkg::ctrlT ctrl,
   input  logic [15:0]   writeData,
   output logic [15:0]   rsVal,
   output logic [15:0]   rtVal,
   output logic [15:0]   imm,
   output logic [2:0]    destReg,
   output logic          regWrite
);

   logic [15:0] regs [8];

   assign rsVal    = regs[instr[10:8]];                   // Source, also branch test reg
   assign rtVal    = regs[instr[7:5]];                    // Second operand or store data
   assign regWrite = ctrl.regWrite;                       // Also feeds the retire trace

   always_comb begin
      case (ctrl.regDest)
         procPkg::destLow:  destReg = instr[4:2];
         procPkg::destMid:  destReg = instr[7:5];
         procPkg::destHigh: destReg = instr[10:8];
         default:           destReg = instr[7:5];
      endcase
   end

   always_comb begin
      if (ctrl.branch == procPkg::brJump) begin
         imm = {{5{instr[10]}}, instr[10:0]};             // J offset
      end else if (ctrl.immWide) begin
         imm = {{8{instr[7]}}, instr[7:0]};               // LBI, BEQZ, BNEZ
      end else begin
         imm = {{11{instr[4]}}, instr[4:0]};              // I-type
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'd0;
         end
      end else if (ctrl.regWrite) begin
         regs[destReg] <= writeData;
      end
   end

endmodule

// File: hw/execute.sv
// Combinational ALU and branch resolve; targets are PC + 1 + sign-extended offset in words
`timescale 1ns/1ps

module execute (
   input  logic [15:0]   rsVal,
   input  logic [15:0]   rtVal,
   input  logic [15:0]   imm,
   input  logic [15:0]   pc,
   input  procPkg::ctrlT ctrl,
   output logic [15:0]   aluResult,
   output logic          taken,
   output logic [15:0]   target
);

   logic [15:0] opB;
   logic [15:0] aluOut;
   logic        rsZero;

   assign opB = ctrl.aluSrcImm ? imm : rtVal;

   always_comb begin
      case (ctrl.aluOp)
         procPkg::aluAdd: aluOut = rsVal + opB;
         procPkg::aluSub: aluOut = rsVal - opB;            // SUBI is rs minus imm
         procPkg::aluXor: aluOut = rsVal ^ opB;
         procPkg::aluAnd: aluOut = rsVal & opB;
         default:         aluOut = rsVal + opB;
      endcase
   end

   // Only LBI writes back with the wide immediate
   assign aluResult = ctrl.immWide ? imm : aluOut;

   assign rsZero = (rsVal == 16'd0);

   always_comb begin
      case (ctrl.branch)
         procPkg::brNone:      taken = 1'b0;
         procPkg::brIfZero:    taken = rsZero;
         procPkg::brIfNotZero: taken = !rsZero;
         procPkg::brJump:      taken = 1'b1;
         default:              taken = 1'b0;
      endcase
   end

   assign target = pc + 16'd1 + imm;                      // Relative to next PC

endmodule

// File: hw/memory.sv
// 256-word data memory with no reset, synchronous write and asynchronous read; upper address byte must be zero
`timescale 1ns/1ps

module memory (
   input  logic          clk,
   input  logic [15:0]   aluResult,
   input  logic [15:0]   storeData,
   input  procPkg::ctrlT ctrl,
   output logic [15:0]   writeData
);

   logic [15:0]                  dmem [procPkg::dmemDepth];
   logic [procPkg::addrBits-1:0] addr;
   logic [15:0]                  readWord;

   assign addr = aluResult[procPkg::addrBits-1:0];         // Word index

   always_ff @(posedge clk) begin
      if (ctrl.memWrite) dmem[addr] <= storeData;
   end

   assign readWord  = ctrl.memRead ? dmem[addr] : 16'd0;
   assign writeData = ctrl.memToReg ? readWord : aluResult;  // Writeback mux

   // A nonzero high byte would alias into the low 256 words
   assert property (@(posedge clk)
      (ctrl.memRead || ctrl.memWrite) |-> (aluResult[15:procPkg::addrBits] == '0))
      else $error("memory: address 0x%04h out of range", aluResult);

endmodule

// File: hw/proc.sv
// Single-cycle core top; load imem and pulse start while idle, retire pulses one cycle after each register write
`timescale 1ns/1ps

module proc (
   input  logic              clk,
   input  logic              arstN,
   input  procPkg::imemLoadT imemLoad,
   input  logic              start,
   output procPkg::retireT   retire,
   output logic              halted,
   output logic              err
);

   procPkg::ctrlT ctrl;
   logic          illegal;
   logic [15:0]   instr;                                  // Fetch to control and decode
   logic [15:0]   pc;
   logic          taken;                                  // Execute back to fetch
   logic [15:0]   target;
   logic [15:0]   rsVal;
   logic [15:0]   rtVal;
   logic [15:0]   imm;
   logic [2:0]    destReg;
   logic          regWrite;
   logic [15:0]   aluResult;                              // Execute to memory
   logic [15:0]   writeData;                              // Memory back to decode

   control control0 (.instr(instr), .ctrl(ctrl), .illegal(illegal));

   fetch fetch0 (.clk(clk), .arstN(arstN), .imemLoad(imemLoad), .start(start),
                 .ctrl(ctrl), .illegal(illegal), .taken(taken), .target(target),
                 .instr(instr), .pc(pc), .halted(halted), .err(err));

   decode decode0 (.clk(clk), .arstN(arstN), .instr(instr), .ctrl(ctrl),
                   .writeData(writeData), .rsVal(rsVal), .rtVal(rtVal), .imm(imm),
                   .destReg(destReg), .regWrite(regWrite));

   execute execute0 (.rsVal(rsVal), .rtVal(rtVal), .imm(imm), .pc(pc), .ctrl(ctrl),
                     .aluResult(aluResult), .taken(taken), .target(target));

   memory memory0 (.clk(clk), .aluResult(aluResult), .storeData(rtVal), .ctrl(ctrl),
                   .writeData(writeData));

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         retire <= '0;
      end else begin
         retire.valid  <= regWrite;                       // Same edge as the regfile write
         retire.regNum <= destReg;
         retire.data   <= writeData;
      end
   end

endmodule

// File: verification/procTb.sv
// Directed tests of the single-cycle core; data memory and registers persist, so tests run in order
`timescale 1ns/1ps

module procTb;

   localparam int cycleLimit = 2000;                     // Reset plus six tests of ~150 cycles

   logic              clk;
   logic              arstN;
   logic              start;
   procPkg::imemLoadT imemLoad;
   procPkg::retireT   retire;
   logic              halted;
   logic              err;

   logic [15:0] prog [$];                                // Program under construction
   logic [18:0] expQ [$];                                // Pending {reg, value} retires
   logic [15:0] mRegs [8];                               // Reference register file
   logic [15:0] mMem [256];                              // Reference data memory
   logic [18:0] front;
   logic [31:0] seed;
   int          errors;
   int          lastErrors;
   int          testsRun;
   int          cycles;

   proc UUT (.clk(clk), .arstN(arstN), .imemLoad(imemLoad), .start(start),
             .retire(retire), .halted(halted), .err(err));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [15:0] assemble(procPkg::opcodeT op, int ra, int rb, int rc, int imm);
      case (op)
         procPkg::opAlu: return {op, ra[2:0], rb[2:0], rc[2:0], imm[1:0]};
         procPkg::opJ: return {op, imm[10:0]};
         procPkg::opLbi, procPkg::opBeqz, procPkg::opBnez: return {op, ra[2:0], imm[7:0]};
         default: return {op, ra[2:0], rb[2:0], imm[4:0]};  // rs, rd or rt, imm5
      endcase
   endfunction

   function logic [31:0] nextRandom();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic emit(procPkg::opcodeT op, int ra, int rb, int rc, int imm);
      prog.push_back(assemble(op, ra, rb, rc, imm));
   endtask

   task automatic pushExpected(logic [2:0] r, logic [15:0] v);
      mRegs[r] = v;
      expQ.push_back({r, v});
   endtask

   // Walks the program from word 0 the way the core should, queueing every register write
   task automatic modelRun();
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] rs;
      logic [15:0] rt;
      logic [15:0] i5;
      logic [15:0] i8;
      logic [15:0] addr;
      logic [15:0] v;
      int          steps;
      bit          stop;
      pc = 16'd0;
      steps = 0;
      stop = 1'b0;
      while (!stop && steps < 500) begin
         w    = prog[pc];
         rs   = mRegs[w[10:8]];
         rt   = mRegs[w[7:5]];
         i5   = {{11{w[4]}}, w[4:0]};
         i8   = {{8{w[7]}}, w[7:0]};
         addr = rs + i5;
         pc   = pc + 16'd1;                              // Targets count from the next word
         steps++;
         case (procPkg::opcodeT'(w[15:11]))
            procPkg::opNop: ;
            procPkg::opJ:    pc = pc + {{5{w[10]}}, w[10:0]};
            procPkg::opAddi: pushExpected(w[7:5], rs + i5);
            procPkg::opSubi: pushExpected(w[7:5], rs - i5);
            procPkg::opAndi: pushExpected(w[7:5], rs & i5);
            procPkg::opBeqz: if (rs == 16'd0) pc = pc + i8;
            procPkg::opBnez: if (rs != 16'd0) pc = pc + i8;
            procPkg::opSt:   mMem[addr[7:0]] = rt;
            procPkg::opLd:   pushExpected(w[7:5], mMem[addr[7:0]]);
            procPkg::opLbi:  pushExpected(w[10:8], i8);
            procPkg::opAlu: begin
               case (w[1:0])
                  2'd0:    v = rs + rt;
                  2'd1:    v = rs - rt;
                  2'd2:    v = rs ^ rt;
                  default: v = rs & rt;
               endcase
               pushExpected(w[4:2], v);
            end
            default: stop = 1'b1;                        // HALT or illegal opcode
         endcase
      end
   endtask

   task automatic loadProgram();
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         imemLoad.valid <= 1'b1;
         imemLoad.addr  <= 8'(i);
         imemLoad.data  <= prog[i];
      end
      @(posedge clk);
      imemLoad.valid <= 1'b0;
   endtask

   task automatic runProgram(bit expectErr);
      loadProgram();
      modelRun();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);                                    // Old halted clears at the start edge
      while (!halted && !err) @(posedge clk);
      repeat (2) @(posedge clk);                         // Drain the last retire
      if (halted !== 1'b1 || err !== expectErr) begin
         $display("ERR %0t: halted=%b err=%b, expected 1 and %b", $time, halted, err, expectErr);
         errors++;
      end
      prog.delete();
   endtask

   task automatic report(string name);
      if (expQ.size() != 0) begin
         $display("%s: %0d expected register writes never retired", name, expQ.size());
         errors++;
         expQ.delete();
      end
      $display("%s: %s", name, (errors == lastErrors) ? "ok" : "failed");
      lastErrors = errors;
      testsRun++;
   endtask

   task automatic immediates();
      emit(procPkg::opLbi, 1, 0, 0, 8'h7f);
      emit(procPkg::opLbi, 2, 0, 0, 8'h80);              // Sign extends to ff80
      emit(procPkg::opAddi, 1, 3, 0, 5);
      emit(procPkg::opSubi, 2, 4, 0, -3);
      emit(procPkg::opAndi, 1, 5, 0, 15);
      emit(procPkg::opAndi, 2, 6, 0, -16);
      emit(procPkg::opAddi, 3, 3, 0, -1);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b0);
      report("immediates");
   endtask

   task automatic randomRType();
      logic [31:0] r;
      for (int k = 0; k < 3; k++) begin
         r = nextRandom();
         emit(procPkg::opLbi, 1, 0, 0, int'(r[7:0]));
         emit(procPkg::opLbi, 2, 0, 0, int'(r[23:16]));
         emit(procPkg::opAlu, 1, 2, 3, 0);               // add
         emit(procPkg::opAlu, 1, 2, 4, 1);               // sub
         emit(procPkg::opAlu, 3, 4, 5, 2);               // xor
         emit(procPkg::opAlu, 5, 1, 6, 3);               // and
      end
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b0);
      report("random R-type");
   endtask

   task automatic memoryPersist();
      emit(procPkg::opLbi, 1, 0, 0, 10);
      emit(procPkg::opLbi, 2, 0, 0, -77);
      emit(procPkg::opSt, 1, 2, 0, 5);                   // mem[15] = r2
      emit(procPkg::opLd, 1, 3, 0, 5);
      emit(procPkg::opLbi, 4, 0, 0, 8'h33);
      emit(procPkg::opSt, 1, 4, 0, -2);                  // mem[8] = r4
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b0);
      emit(procPkg::opLbi, 1, 0, 0, 4);                  // Second run only reads
      emit(procPkg::opLd, 1, 5, 0, 4);
      emit(procPkg::opLd, 1, 6, 0, 11);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b0);
      report("memory");
   endtask

   task automatic controlFlow();
      emit(procPkg::opLbi, 1, 0, 0, 0);
      emit(procPkg::opLbi, 2, 0, 0, 3);
      emit(procPkg::opBeqz, 1, 0, 0, 1);                 // Taken over word 3
      emit(procPkg::opLbi, 3, 0, 0, 8'h11);
      emit(procPkg::opBnez, 1, 0, 0, 1);                 // Falls through
      emit(procPkg::opLbi, 3, 0, 0, 8'h22);
      emit(procPkg::opBnez, 2, 0, 0, 2);                 // Taken to word 9
      emit(procPkg::opLbi, 4, 0, 0, 8'h44);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      emit(procPkg::opBeqz, 2, 0, 0, 1);
      emit(procPkg::opJ, 0, 0, 0, 1);
      emit(procPkg::opLbi, 5, 0, 0, 8'h55);
      emit(procPkg::opAddi, 2, 6, 0, -1);
      emit(procPkg::opJ, 0, 0, 0, -6);                   // Back to the HALT at word 8
      runProgram(1'b0);
      report("control flow");
   endtask

   task automatic haltReload();
      emit(procPkg::opLbi, 1, 0, 0, 1);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      emit(procPkg::opLbi, 2, 0, 0, 2);
      runProgram(1'b0);
      repeat (20) begin
         @(posedge clk);
         if (halted !== 1'b1) begin
            $display("ERR %0t: halted=%b while parked, expected 1", $time, halted);
            errors++;
         end
      end
      emit(procPkg::opLbi, 7, 0, 0, 8'h3c);
      emit(procPkg::opAddi, 7, 7, 0, 1);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b0);
      report("halt and reload");
   endtask

   task automatic illegalOpcode();
      emit(procPkg::opLbi, 1, 0, 0, 7);
      prog.push_back(16'hf800);                          // Opcode 11111 is unassigned
      emit(procPkg::opLbi, 2, 0, 0, 9);
      emit(procPkg::opHalt, 0, 0, 0, 0);
      runProgram(1'b1);
      repeat (10) @(posedge clk);
      report("illegal opcode");
   endtask

   always @(posedge clk) begin
      if (arstN && retire.valid) begin
         if (expQ.size() == 0) begin
            $display("Unexpected retire of r%0d at %0t with no write pending", retire.regNum, $time);
            errors++;
         end else begin
            front = expQ.pop_front();
            if (retire.regNum !== front[18:16] || retire.data !== front[15:0]) begin
               $display("ERR %0t: retire r%0d=%04h, expected r%0d=%04h", $time, retire.regNum,
                        retire.data, front[18:16], front[15:0]);
               errors++;
            end
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      arstN      = 1'b0;
      start      = 1'b0;
      imemLoad   = '0;
      seed       = 32'h8bc9_7d97;
      errors     = 0;
      lastErrors = 0;
      testsRun   = 0;
      for (int i = 0; i < 8; i++) begin
         mRegs[i] = 16'd0;                               // Matches the register reset
      end
      repeat (16) @(posedge clk);
      arstN <= 1'b1;
      @(posedge clk);
      immediates();
      randomRType();
      memoryPersist();
      controlFlow();
      haltReload();
      illegalOpcode();
      $display("Summary: %0d tests run, %0d errors", testsRun, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: project.f
hw/procPkg.sv
hw/control.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/proc.sv
verification/procTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module procTb -o procSim
./obj_dir/procSim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
   exit 0
fi
exit 1
